//--- hw/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// byte wide datapath, registers and addresses share this width
`define CPU_DATA_W 8

// instructions are two bytes, stored big-endian in memory
`define CPU_INST_W 16

// r0 to r15, addressed by one nibble of the instruction
`define CPU_NUM_REGS 16

`define CPU_RESET_PC 8'h00  // first fetch reads the high byte here

`endif

//--- hw/isa_pkg.sv
`default_nettype none

`include "cpu_params.svh"

package isa_pkg;

    typedef enum logic [3:0] {
        OP_JMP  = 4'd0,  // pc = ra
        OP_LOD  = 4'd1,  // ra = mem[rb]
        OP_STR  = 4'd2,  // mem[rb] = ra
        OP_ADD  = 4'd3,  // ra = rb + rc
        OP_ADDI = 4'd4,  // ra = ra + imm
        OP_LODI = 4'd5,  // ra = imm
        OP_NAND = 4'd6,  // ra = ~(rb & rc)
        OP_JEQZ = 4'd7   // pc = rb if ra is zero
    } opcode_e;

    typedef struct packed {
        opcode_e                          op;
        logic [$clog2(`CPU_NUM_REGS)-1:0] dest;
        logic [$clog2(`CPU_NUM_REGS)-1:0] src_a;
        logic [$clog2(`CPU_NUM_REGS)-1:0] src_b;  // memory address register for LOD and STR
        logic [`CPU_DATA_W-1:0]           imm;
        logic                             writes_reg;
    } decoded_t;

endpackage

`default_nettype wire

//--- hw/bus_pkg.sv
`default_nettype none

`include "cpu_params.svh"

package bus_pkg;

    // one request toward external memory, held until mem_ready
    typedef struct packed {
        logic                   req;
        logic                   we;
        logic [`CPU_DATA_W-1:0] addr;
        logic [`CPU_DATA_W-1:0] wdata;
    } mem_req_t;

    // encoded as {en, ready} of a stage
    typedef enum logic [1:0] {
        IDLE      = 2'b00,
        RESETTING = 2'b01,  // en already dropped, ready falls next cycle
        BUSY      = 2'b10,
        COMPLETE  = 2'b11
    } stage_state_e;

endpackage

`default_nettype wire

//--- hw/fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module fetch (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    en,
    input  wire [`CPU_DATA_W-1:0]  pc,
    input  wire                    mem_ready,
    input  wire [`CPU_DATA_W-1:0]  mem_rdata,
    output logic                   mem_req,
    output logic [`CPU_DATA_W-1:0] mem_addr,
    output logic [`CPU_INST_W-1:0] inst,
    output logic                   ready
);
    typedef enum logic [1:0] {F_IDLE, F_HI, F_LO, F_DONE} fetch_state_e;

    fetch_state_e           state;
    logic [`CPU_DATA_W-1:0] base;  // address of the high byte, stable for the whole access
    logic                   abort;  // en fell while a read was still on the bus
    logic                   drop;

    assign drop     = abort || !en;
    assign mem_req  = (state == F_HI) || (state == F_LO);
    assign mem_addr = (state == F_LO) ? base + 1'b1 : base;
    assign ready    = (state == F_DONE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= F_IDLE;
            abort <= 1'b0;
        end else begin
            case (state)
                F_IDLE: begin
                    abort <= 1'b0;
                    if (en) begin
                        state <= F_HI;
                    end
                end
                F_HI, F_LO: begin
                    if (!en) begin
                        abort <= 1'b1;  // the current byte still completes on the bus
                    end
                    if (mem_ready) begin
                        if (drop) begin
                            state <= F_IDLE;
                        end else begin
                            state <= (state == F_HI) ? F_LO : F_DONE;
                        end
                    end
                end
                default: begin
                    if (!en) begin
                        state <= F_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == F_IDLE && en) begin
            base <= pc;
        end
        if (state == F_HI && mem_ready) begin
            inst[`CPU_INST_W-1 -: `CPU_DATA_W] <= mem_rdata;
        end
        if (state == F_LO && mem_ready) begin
            inst[`CPU_DATA_W-1:0] <= mem_rdata;
        end
    end

endmodule

`default_nettype wire

//--- hw/decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module decode (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   en,
    input  wire [`CPU_INST_W-1:0] inst,
    output isa_pkg::decoded_t     dec,
    output logic                  ready
);
    import isa_pkg::*;

    opcode_e                          op;
    logic [$clog2(`CPU_NUM_REGS)-1:0] ra, rb, rc;
    logic [$clog2(`CPU_NUM_REGS)-1:0] src_a, src_b;
    logic                             writes;

    assign op = opcode_e'(inst[15:12]);
    assign ra = inst[11:8];
    assign rb = inst[7:4];
    assign rc = inst[3:0];

    // ra and rb cover STR, JEQZ, JMP, ADDI and LOD, whose address sits in rb
    always_comb begin
        src_a  = ra;
        src_b  = rb;
        writes = 1'b0;
        case (op)
            OP_ADD, OP_NAND: begin
                src_a  = rb;
                src_b  = rc;
                writes = 1'b1;
            end
            OP_LOD, OP_ADDI, OP_LODI: writes = 1'b1;
            default: writes = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ready <= 1'b0;
        end else begin
            ready <= en;  // one cycle to decode, falls one cycle after en
        end
    end

    always_ff @(posedge clk) begin
        if (en && !ready) begin
            dec.op         <= op;
            dec.dest       <= ra;
            dec.src_a      <= src_a;
            dec.src_b      <= src_b;
            dec.imm        <= inst[`CPU_DATA_W-1:0];
            dec.writes_reg <= writes;
        end
    end

endmodule

`default_nettype wire

//--- hw/exec.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module exec (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    en,
    input  wire isa_pkg::decoded_t dec,
    input  wire [`CPU_DATA_W-1:0]  opa,
    input  wire [`CPU_DATA_W-1:0]  opb,
    input  wire [`CPU_DATA_W-1:0]  pc,
    input  wire                    mem_ready,
    input  wire [`CPU_DATA_W-1:0]  mem_rdata,
    output bus_pkg::mem_req_t      mem,
    output logic [`CPU_DATA_W-1:0] result,
    output logic [`CPU_DATA_W-1:0] branch_pc,
    output logic                   flush,
    output logic                   ready
);
    import isa_pkg::*;

    typedef enum logic [1:0] {E_IDLE, E_MEM, E_DONE} exec_state_e;

    exec_state_e state;
    logic        taken;
    logic        is_mem;

    assign is_mem = (dec.op == OP_LOD) || (dec.op == OP_STR);
    assign ready  = (state == E_DONE);
    assign flush  = ready && taken;

    // top level holds dec and the operands steady while this stage is enabled
    assign mem.req   = (state == E_MEM);
    assign mem.we    = (state == E_MEM) && (dec.op == OP_STR);
    assign mem.addr  = opb;
    assign mem.wdata = opa;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= E_IDLE;
            taken <= 1'b0;
        end else begin
            case (state)
                E_IDLE: begin
                    if (en) begin
                        state <= is_mem ? E_MEM : E_DONE;
                        taken <= (dec.op == OP_JMP) || (dec.op == OP_JEQZ && opa == '0);
                    end
                end
                E_MEM: begin
                    if (mem_ready) begin
                        state <= E_DONE;
                    end
                end
                default: begin
                    if (!en) begin
                        state <= E_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == E_IDLE && en) begin
            case (dec.op)
                OP_ADD:  result <= opa + opb;
                OP_ADDI: result <= opa + dec.imm;
                OP_LODI: result <= dec.imm;
                OP_NAND: result <= ~(opa & opb);
                default: result <= opa;
            endcase
            case (dec.op)
                OP_JMP:  branch_pc <= opa;
                OP_JEQZ: branch_pc <= (opa == '0) ? opb : pc;
                default: branch_pc <= pc;  // pc already points past this instruction
            endcase
        end
        if (state == E_MEM && mem_ready) begin
            result <= mem_rdata;  // only LOD writes it back
        end
    end

endmodule

`default_nettype wire

//--- hw/writeback.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module writeback (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 en,
    input  wire                                 we,
    input  wire [$clog2(`CPU_NUM_REGS)-1:0]     waddr,
    input  wire [`CPU_DATA_W-1:0]               wdata,
    input  wire [$clog2(`CPU_NUM_REGS)-1:0]     raddr_a,
    input  wire [$clog2(`CPU_NUM_REGS)-1:0]     raddr_b,
    output logic [`CPU_DATA_W-1:0]              rdata_a,
    output logic [`CPU_DATA_W-1:0]              rdata_b,
    output logic                                ready
);
    logic [`CPU_DATA_W-1:0] regs [`CPU_NUM_REGS];

    // operands are read only while execute and writeback are idle
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ready <= 1'b0;
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            ready <= en;
            if (en && !ready && we) begin
                regs[waddr] <= wdata;  // single write per enable
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/eightbit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module eightbit (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   mem_ready,
    input  wire [`CPU_DATA_W-1:0] mem_rdata,
    output bus_pkg::mem_req_t     mem
);
    import isa_pkg::*;
    import bus_pkg::*;

    logic [`CPU_DATA_W-1:0] pc;
    logic [`CPU_DATA_W-1:0] dec_pc;  // address after the instruction sitting in decode
    logic [`CPU_DATA_W-1:0] exec_pc;

    logic                   fetch_en, fetch_ready, fetch_mem_req, fetch_mem_ready;
    logic                   fetch_hold;  // fetch owns the bus until its second byte
    logic [`CPU_DATA_W-1:0] fetch_addr;
    logic [`CPU_INST_W-1:0] fetch_inst;

    logic                   decode_en, decode_ready;
    logic [`CPU_INST_W-1:0] decode_inst;
    decoded_t               decode_out;

    logic                   exec_en, exec_ready, exec_flush, exec_mem_ready;
    decoded_t               exec_dec;
    logic [`CPU_DATA_W-1:0] exec_opa, exec_opb, exec_result, exec_branch_pc;
    mem_req_t               exec_mem;

    logic                             wb_en, wb_ready, wb_we;
    logic [$clog2(`CPU_NUM_REGS)-1:0] wb_waddr;
    logic [`CPU_DATA_W-1:0]           wb_wdata, rdata_a, rdata_b;

    stage_state_e fetch_st, decode_st, exec_st, wb_st;
    logic         take_fetch, take_decode, take_exec, grant_exec;

    function automatic logic can_start(input stage_state_e st);
        return (st == IDLE) || (st == RESETTING);
    endfunction

    assign fetch_st  = stage_state_e'({fetch_en, fetch_ready});
    assign decode_st = stage_state_e'({decode_en, decode_ready});
    assign exec_st   = stage_state_e'({exec_en, exec_ready});
    assign wb_st     = stage_state_e'({wb_en, wb_ready});

    assign take_fetch  = (fetch_st == COMPLETE) && (decode_st == IDLE);
    assign take_decode = (decode_st == COMPLETE) && can_start(exec_st) && can_start(wb_st);
    assign take_exec   = (exec_st == COMPLETE) && can_start(wb_st);

    fetch u_fetch (
        .clk(clk), .rst(rst), .en(fetch_en), .pc(pc),
        .mem_ready(fetch_mem_ready), .mem_rdata(mem_rdata),
        .mem_req(fetch_mem_req), .mem_addr(fetch_addr), .inst(fetch_inst), .ready(fetch_ready)
    );

    decode u_decode (
        .clk(clk), .rst(rst), .en(decode_en), .inst(decode_inst),
        .dec(decode_out), .ready(decode_ready)
    );

    exec u_exec (
        .clk(clk), .rst(rst), .en(exec_en), .dec(exec_dec),
        .opa(exec_opa), .opb(exec_opb), .pc(exec_pc),
        .mem_ready(exec_mem_ready), .mem_rdata(mem_rdata), .mem(exec_mem),
        .result(exec_result), .branch_pc(exec_branch_pc), .flush(exec_flush),
        .ready(exec_ready)
    );

    writeback u_writeback (
        .clk(clk), .rst(rst), .en(wb_en), .we(wb_we), .waddr(wb_waddr), .wdata(wb_wdata),
        .raddr_a(decode_out.src_a), .raddr_b(decode_out.src_b),
        .rdata_a(rdata_a), .rdata_b(rdata_b), .ready(wb_ready)
    );

    assign grant_exec = exec_mem.req && !fetch_hold;

    always_comb begin
        mem             = '0;
        fetch_mem_ready = 1'b0;
        exec_mem_ready  = 1'b0;
        if (grant_exec) begin
            mem            = exec_mem;
            exec_mem_ready = mem_ready;
        end else if (fetch_mem_req) begin
            mem.req         = 1'b1;
            mem.addr        = fetch_addr;
            fetch_mem_ready = mem_ready;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fetch_hold <= 1'b0;
            pc         <= `CPU_RESET_PC;
            fetch_en   <= 1'b0;
            decode_en  <= 1'b0;
            exec_en    <= 1'b0;
            wb_en      <= 1'b0;
        end else begin
            fetch_hold <= fetch_mem_req && !grant_exec;
            if (can_start(fetch_st)) begin
                fetch_en <= 1'b1;
            end
            if (take_fetch) begin
                fetch_en  <= 1'b0;
                decode_en <= 1'b1;
                pc        <= pc + 2'd2;
            end
            if (take_decode) begin
                decode_en <= 1'b0;
                exec_en   <= 1'b1;
            end
            if (take_exec) begin
                exec_en <= 1'b0;
                if (exec_flush) begin
                    pc        <= exec_branch_pc;  // overrides any hand-off in this cycle
                    fetch_en  <= 1'b0;
                    decode_en <= 1'b0;
                end else begin
                    wb_en <= 1'b1;
                end
            end
            if (wb_st == COMPLETE) begin
                wb_en <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_fetch) begin
            decode_inst <= fetch_inst;
            dec_pc      <= pc + 2'd2;
        end
        if (take_decode) begin
            exec_dec <= decode_out;
            exec_opa <= rdata_a;
            exec_opb <= rdata_b;
            exec_pc  <= dec_pc;
        end
        if (take_exec && !exec_flush) begin
            wb_we    <= exec_dec.writes_reg;
            wb_waddr <= exec_dec.dest;
            wb_wdata <= exec_result;
        end
    end

endmodule

`default_nettype wire

//--- dv/eightbit_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module eightbit_checker (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    start,
    input  wire bus_pkg::mem_req_t mem,
    input  wire                    mem_ready,
    input  logic [`CPU_DATA_W-1:0] image [256],
    input  int                     exp_count,
    input  logic [`CPU_DATA_W-1:0] exp_last,
    output logic                   done,
    output int                     errors,
    output int                     stores
);
    import isa_pkg::*;

    logic [`CPU_DATA_W-1:0] exp_addr [32];
    logic [`CPU_DATA_W-1:0] exp_data [32];
    int                     exp_n = 0;
    int                     obs_n = 0;
    int                     err_cnt = 0;
    int                     store_cnt = 0;
    logic                   seen_req = 1'b0;

    assign errors = err_cnt;
    assign stores = store_cnt;

    // runs the instruction set on a private copy of memory until the store to 0xff
    task automatic build_expected();
        logic [`CPU_DATA_W-1:0] m [256];
        logic [`CPU_DATA_W-1:0] r [16];
        logic [`CPU_DATA_W-1:0] pc;
        logic [15:0]            iw;
        logic [3:0]             ra, rb, rc;
        logic                   stop;
        for (int a = 0; a < 256; a++) begin
            m[a] = image[a];
        end
        for (int i = 0; i < 16; i++) begin
            r[i] = 8'h00;
        end
        pc    = `CPU_RESET_PC;
        stop  = 1'b0;
        exp_n = 0;
        for (int step = 0; step < 256 && !stop; step++) begin
            iw = {m[pc], m[pc + 8'd1]};
            ra = iw[11:8];
            rb = iw[7:4];
            rc = iw[3:0];
            pc = pc + 8'd2;
            case (opcode_e'(iw[15:12]))
                OP_JMP:  pc = r[ra];
                OP_LOD:  r[ra] = m[r[rb]];
                OP_STR: begin
                    m[r[rb]] = r[ra];
                    if (exp_n < 32) begin
                        exp_addr[exp_n] = r[rb];
                        exp_data[exp_n] = r[ra];
                        exp_n++;
                    end
                    stop = (r[rb] == 8'hFF);
                end
                OP_ADD:  r[ra] = r[rb] + r[rc];
                OP_ADDI: r[ra] = r[ra] + iw[7:0];
                OP_LODI: r[ra] = iw[7:0];
                OP_NAND: r[ra] = ~(r[rb] & r[rc]);
                OP_JEQZ: pc = (r[ra] == 8'h00) ? r[rb] : pc;
                default: ;
            endcase
        end
    endtask

    always @(posedge clk) begin
        if (start) begin
            build_expected();
        end
        if (rst) begin
            done    <= 1'b0;
            obs_n    = 0;
            seen_req = 1'b0;
            if (mem.req || mem.we) begin
                $display("MISMATCH at %0t: req %b we %b during reset, expected both low",
                         $time, mem.req, mem.we);
                err_cnt++;
            end
        end else begin
            if (mem.req && !seen_req) begin
                seen_req = 1'b1;  // first access after reset is the high byte at the reset pc
                if (mem.addr != `CPU_RESET_PC || mem.we) begin
                    $display("MISMATCH at %0t: first access to %h we %b, expected a read of %h",
                             $time, mem.addr, mem.we, `CPU_RESET_PC);
                    err_cnt++;
                end
            end
            if (mem.req && mem.we && mem_ready) begin
                store_cnt++;
                if (obs_n >= exp_n) begin
                    $display("MISMATCH at %0t: store of %h to %h beyond the %0d predicted",
                             $time, mem.wdata, mem.addr, exp_n);
                    err_cnt++;
                end else if (mem.addr != exp_addr[obs_n] || mem.wdata != exp_data[obs_n]) begin
                    $display("MISMATCH at %0t: store %0d wrote %h to %h, expected %h to %h",
                             $time, obs_n, mem.wdata, mem.addr, exp_data[obs_n],
                             exp_addr[obs_n]);
                    err_cnt++;
                end
                if (mem.addr == 8'hFF) begin
                    done <= 1'b1;
                    if (obs_n + 1 != exp_count || mem.wdata != exp_last) begin
                        $display("MISMATCH at %0t: %0d stores ending in %h, table has %0d and %h",
                                 $time, obs_n + 1, mem.wdata, exp_count, exp_last);
                        err_cnt++;
                    end
                end
                obs_n++;
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_eightbit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module tb_eightbit;
    import bus_pkg::*;

    localparam int NUM_ROWS       = 5;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 64 * 20;

    // each program ends with a store to 0xff and a jump to itself
    localparam logic [15:0] PROG [NUM_ROWS][16] = '{
        '{16'h517F, 16'h5290, 16'h3312, 16'h43F5, 16'h6413, 16'h5FFF, 16'h5E80, 16'h23E0,
          16'h24F0, 16'h5D14, 16'h0D00, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
        '{16'h5180, 16'h1210, 16'h4201, 16'h5390, 16'h2230, 16'h1430, 16'h4101, 16'h1510,
          16'h3645, 16'h5FFF, 16'h26F0, 16'h5D18, 16'h0D00, 16'h0000, 16'h0000, 16'h0000},
        '{16'h510A, 16'h5FFF, 16'h5255, 16'h0100, 16'h22F0, 16'h5312, 16'h5400, 16'h7430,
          16'h22F0, 16'h42AB, 16'h5580, 16'h2250, 16'h4207, 16'h22F0, 16'h5D1E, 16'h0D00},
        '{16'h5103, 16'h5220, 16'h7120, 16'h41FF, 16'h3111, 16'h6311, 16'h5FFF, 16'h2320,
          16'h3431, 16'h24F0, 16'h5D16, 16'h0D00, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
        '{16'h5103, 16'h520C, 16'h5306, 16'h7120, 16'h41FF, 16'h0300, 16'h54C0, 16'h2140,
          16'h5FFF, 16'h4411, 16'h24F0, 16'h5D18, 16'h0D00, 16'h0000, 16'h0000, 16'h0000}
    };
    localparam logic [7:0] DATA [NUM_ROWS][2] = '{
        '{8'h00, 8'h00}, '{8'h3C, 8'hA5}, '{8'h00, 8'h00}, '{8'h00, 8'h00}, '{8'h00, 8'h00}
    };
    localparam int         LATENCY    [NUM_ROWS] = '{0, 1, 2, 3, 0};
    localparam int         EXP_STORES [NUM_ROWS] = '{2, 2, 2, 2, 2};
    localparam logic [7:0] EXP_LAST   [NUM_ROWS] = '{8'hFB, 8'hE2, 8'h07, 8'hFF, 8'hD1};

    logic                   clk       = 1'b0;
    logic                   rst       = 1'b1;
    logic                   mem_ready = 1'b0;
    logic [`CPU_DATA_W-1:0] mem_rdata = 8'h00;
    logic                   start     = 1'b0;
    mem_req_t               mem;

    logic [`CPU_DATA_W-1:0] image [256];  // memory contents at the start of a row
    logic [`CPU_DATA_W-1:0] ram [256];
    int                     extra [256];
    logic [7:0]             acc_idx = 8'h00;
    int                     wait_cnt = 0;
    int                     latency = 0;
    int                     exp_count = 0;
    logic [`CPU_DATA_W-1:0] exp_last = 8'h00;
    int                     cycles = 0;
    logic                   done;
    int                     errors;
    int                     stores;

    always #2 clk = ~clk;

    eightbit dut (
        .clk(clk), .rst(rst), .mem_ready(mem_ready), .mem_rdata(mem_rdata), .mem(mem)
    );

    eightbit_checker chk (
        .clk(clk), .rst(rst), .start(start), .mem(mem), .mem_ready(mem_ready),
        .image(image), .exp_count(exp_count), .exp_last(exp_last),
        .done(done), .errors(errors), .stores(stores)
    );

    // ready pulses for one cycle once the request has waited its latency
    always @(posedge clk) begin
        if (rst) begin
            mem_ready <= 1'b0;
            wait_cnt  <= 0;
            for (int a = 0; a < 256; a++) begin
                ram[a] <= image[a];
            end
        end else if (mem_ready) begin
            mem_ready <= 1'b0;
            wait_cnt  <= 0;
        end else if (mem.req) begin
            if (wait_cnt >= latency + extra[acc_idx]) begin
                mem_ready <= 1'b1;
                mem_rdata <= ram[mem.addr];
                acc_idx   <= acc_idx + 8'd1;
                if (mem.we) begin
                    ram[mem.addr] <= mem.wdata;
                end
            end else begin
                wait_cnt <= wait_cnt + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the programs did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic load_row(input int row);
        for (int a = 0; a < 256; a++) begin
            image[a] = 8'(a) ^ 8'h5A;  // unused bytes differ by address
        end
        for (int w = 0; w < 16; w++) begin
            image[2 * w]     = PROG[row][w][15:8];
            image[2 * w + 1] = PROG[row][w][7:0];
        end
        image[8'h80] = DATA[row][0];
        image[8'h81] = DATA[row][1];
        latency   = LATENCY[row];
        exp_count = EXP_STORES[row];
        exp_last  = EXP_LAST[row];
    endtask

    initial begin
        void'($urandom(36));
        for (int i = 0; i < 256; i++) begin
            extra[i] = $urandom % 3;
        end
        for (int row = 0; row < NUM_ROWS; row++) begin
            @(posedge clk);
            rst   <= 1'b1;
            start <= 1'b1;
            load_row(row);
            @(posedge clk);
            start <= 1'b0;
            repeat (15) @(posedge clk);
            rst <= 1'b0;
            while (!done) begin
                @(posedge clk);  // the store to 0xff ends the row
            end
        end
        $display("rows run %0d, stores checked %0d, errors %0d", NUM_ROWS, stores, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+hw
hw/isa_pkg.sv
hw/bus_pkg.sv
hw/fetch.sv
hw/decode.sv
hw/exec.sv
hw/writeback.sv
hw/eightbit.sv
dv/eightbit_checker.sv
dv/tb_eightbit.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= tb_eightbit
FILELIST  ?= verilog.f
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx ">>> PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
